// ==== filelist.f ====
+incdir+bench
common/riscv_pkg.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/mem_wb_pipeline.sv
writeback/reg_file.sv
writeback/csr_file.sv
writeback/wb_stage.sv
rtl/back_end_top.sv
bench/back_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the back-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module back_end_tb \
  -Mdir obj_dir -o back_end_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/back_end_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== bench/back_end_model.svh ====
// Architectural state and the single WB slot, kept in step with the DUT edges

typedef struct packed {
  logic                  valid;
  logic [reg_addr_w-1:0] rd_addr;
  logic [xlen-1:0]       rd_wdata;
  logic                  rd_write;
  logic [csr_addr_w-1:0] csr_addr;
  logic [xlen-1:0]       csr_wdata;
  logic                  csr_write;
  logic                  trap;
  logic [xlen-1:0]       cause;
  logic [xlen-1:0]       pc;
} slot_t;

slot_t                 slot;
logic [xlen-1:0]       m_regs [32];
logic [7:0]            m_mem [64];
logic [xlen-1:0]       m_csr [logic [csr_addr_w-1:0]];
logic [reg_addr_w-1:0] last_rd;

task automatic reset_model();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_csr[csr_mscratch] = '0;
  m_csr[csr_mtvec]    = '0;
  m_csr[csr_mepc]     = '0;
  m_csr[csr_mcause]   = '0;
  slot    = '0;
  last_rd = '0;
endtask

// Effects of the instruction in WB land at the edge that ends its cycle
task automatic commit_slot();
  if (slot.valid && slot.trap) begin
    m_csr[csr_mepc]   = slot.pc;
    m_csr[csr_mcause] = slot.cause;
  end else if (slot.valid) begin
    if (slot.rd_write && slot.rd_addr != '0) begin
      m_regs[slot.rd_addr] = slot.rd_wdata;
      last_rd              = slot.rd_addr;
    end
    if (slot.csr_write) begin
      m_csr[slot.csr_addr] = slot.csr_wdata;
    end
  end
endtask

// One rising edge: commit WB, then move MEM into WB by the hazard rule
task automatic step_model();
  slot_t           nxt;
  logic [xlen-1:0] old_csr;
  logic [xlen-1:0] word;
  logic [5:0]      b;
  logic            is_store;
  logic            is_csr;
  logic            misaligned;
  logic            illegal;
  if (reset) begin
    reset_model();
  end else begin
    commit_slot();
    b          = mem_q_alu_result[5:0];
    is_store   = mem_q_mem_op inside {mem_sb, mem_sh, mem_sw};
    is_csr     = mem_q_csr_op != csr_none;
    illegal    = is_csr && !m_csr.exists(mem_q_csr_addr);
    misaligned = (mem_q_mem_op inside {mem_lh, mem_lhu, mem_sh} && b[0]) ||
                 (mem_q_mem_op inside {mem_lw, mem_sw} && b[1:0] != 2'b00);
    old_csr    = (is_csr && !illegal) ? m_csr[mem_q_csr_addr] : '0;
    word       = {m_mem[b + 6'd3], m_mem[b + 6'd2], m_mem[b + 6'd1], m_mem[b]};
    nxt.valid     = mem_q_valid;
    nxt.rd_addr   = mem_q_rd_addr;
    nxt.rd_write  = mem_q_rd_write;
    nxt.csr_addr  = mem_q_csr_addr;
    nxt.csr_write = is_csr;
    nxt.trap      = mem_q_valid && (misaligned || illegal);
    nxt.cause     = illegal  ? cause_illegal_insn :
                    is_store ? cause_store_misaligned : cause_load_misaligned;
    nxt.pc        = mem_q_pc;
    case (mem_q_mem_op)
      mem_lb:  nxt.rd_wdata = {{24{word[7]}}, word[7:0]};
      mem_lbu: nxt.rd_wdata = {24'b0, word[7:0]};
      mem_lh:  nxt.rd_wdata = {{16{word[15]}}, word[15:0]};
      mem_lhu: nxt.rd_wdata = {16'b0, word[15:0]};
      mem_lw:  nxt.rd_wdata = word;
      default: nxt.rd_wdata = is_csr ? old_csr : mem_q_alu_result;
    endcase
    case (mem_q_csr_op)
      csr_rw:  nxt.csr_wdata = mem_q_csr_src;
      csr_rs:  nxt.csr_wdata = old_csr | mem_q_csr_src;
      csr_rc:  nxt.csr_wdata = old_csr & ~mem_q_csr_src;
      default: nxt.csr_wdata = old_csr;
    endcase
    // Stores reach memory only as they leave MEM
    if (mem_q_valid && !nxt.trap && !mem_wb_stall && !ex_mem_stall && !mem_wb_flush) begin
      case (mem_q_mem_op)
        mem_sb:  m_mem[b] = mem_q_store_data[7:0];
        mem_sh:  {m_mem[b + 6'd1], m_mem[b]} = mem_q_store_data[15:0];
        mem_sw:  {m_mem[b + 6'd3], m_mem[b + 6'd2], m_mem[b + 6'd1], m_mem[b]} = mem_q_store_data;
        default: ;
      endcase
    end
    if (mem_wb_flush || (ex_mem_stall && !mem_wb_stall)) begin
      slot.valid = 1'b0;
    end else if (!mem_wb_stall) begin
      slot = nxt;
    end
  end
endtask

// ==== bench/back_end_tb.sv ====
`timescale 1ns/1ps

module back_end_tb;
  import riscv_pkg::*;

  localparam int num_insns   = 2000;
  localparam int watchdog_ns = num_insns * 40 * 20;
  localparam logic [csr_addr_w-1:0] unknown_csr = 12'h7c0;

  logic                  clk_i;
  logic                  reset;
  logic                  mem_wb_stall;
  logic                  ex_mem_stall;
  logic                  mem_wb_flush;
  logic                  mem_q_valid;
  logic [xlen-1:0]       mem_q_pc;
  mem_op_e               mem_q_mem_op;
  logic [xlen-1:0]       mem_q_alu_result;
  logic [xlen-1:0]       mem_q_store_data;
  logic [reg_addr_w-1:0] mem_q_rd_addr;
  logic                  mem_q_rd_write;
  csr_op_e               mem_q_csr_op;
  logic [csr_addr_w-1:0] mem_q_csr_addr;
  logic [xlen-1:0]       mem_q_csr_src;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_rdata;
  logic [xlen-1:0]       rs2_rdata;
  logic                  wb_valid;
  logic                  trap_redirect_valid;
  logic [xlen-1:0]       trap_redirect_pc;

  back_end_top #(
    .ram_words(256)
  ) back_end_top_inst (.*);

  `include "back_end_model.svh"

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_trap(input logic got_valid, input logic [xlen-1:0] got_pc,
                            input logic exp_valid, input logic [xlen-1:0] exp_pc);
    check_flag("trap_redirect_valid", got_valid, exp_valid);
    if (exp_valid) begin
      check_word("trap_redirect_pc", got_pc, exp_pc);
    end
  endtask

  // Byte address in the 64-byte window, now and then misaligned for its size
  function automatic logic [xlen-1:0] pick_address(input int size);
    int a;
    a = 4 * $urandom_range(0, 15) + size * $urandom_range(0, (4 / size) - 1);
    if (size > 1 && $urandom_range(0, 99) < 15) begin
      a = a + 1;
    end
    return 32'(a);
  endfunction

  task automatic gen_instruction();
    logic [xlen-1:0] r;
    int              kind;
    kind             = $urandom_range(0, 99);
    r                = $urandom;
    mem_q_valid      = ($urandom_range(0, 9) != 0);
    mem_q_pc         = {r[31:2], 2'b00};
    mem_q_mem_op     = mem_none;
    mem_q_csr_op     = csr_none;
    mem_q_alu_result = $urandom;
    mem_q_store_data = $urandom;
    r                = $urandom;
    mem_q_rd_addr    = r[4:0];
    mem_q_rd_write   = 1'b1;
    mem_q_csr_addr   = csr_mscratch;
    mem_q_csr_src    = ($urandom_range(0, 9) < 4) ? '0 : $urandom;
    if (kind < 35) begin
      case ($urandom_range(0, 4))
        0:       mem_q_mem_op = mem_lb;
        1:       mem_q_mem_op = mem_lbu;
        2:       mem_q_mem_op = mem_lh;
        3:       mem_q_mem_op = mem_lhu;
        default: mem_q_mem_op = mem_lw;
      endcase
    end else if (kind < 60) begin
      mem_q_rd_write = 1'b0;
      case ($urandom_range(0, 2))
        0:       mem_q_mem_op = mem_sb;
        1:       mem_q_mem_op = mem_sh;
        default: mem_q_mem_op = mem_sw;
      endcase
    end else if (kind < 85) begin
      case ($urandom_range(0, 2))
        0:       mem_q_csr_op = csr_rw;
        1:       mem_q_csr_op = csr_rs;
        default: mem_q_csr_op = csr_rc;
      endcase
      case (r[6:5])
        2'd0:    mem_q_csr_addr = csr_mscratch;
        2'd1:    mem_q_csr_addr = csr_mtvec;
        2'd2:    mem_q_csr_addr = csr_mepc;
        default: mem_q_csr_addr = csr_mcause;
      endcase
      if (r[12:7] < 6'd3) begin
        mem_q_csr_addr = unknown_csr;
      end
    end
    case (mem_q_mem_op)
      mem_lb, mem_lbu, mem_sb: mem_q_alu_result = pick_address(1);
      mem_lh, mem_lhu, mem_sh: mem_q_alu_result = pick_address(2);
      mem_lw, mem_sw:          mem_q_alu_result = pick_address(4);
      default: ;
    endcase
  endtask

  task automatic drive_hazards();
    mem_wb_stall = ($urandom_range(0, 9) == 0);
    ex_mem_stall = ($urandom_range(0, 9) == 0);
    mem_wb_flush = ($urandom_range(0, 9) == 0);
  endtask

  task automatic drive_read_ports();
    logic [xlen-1:0] r;
    r        = $urandom;
    rs1_addr = r[0] ? last_rd : r[5:1];
    rs2_addr = r[10:6];
  endtask

  task automatic check_outputs();
    check_word("rs1_rdata", rs1_rdata, m_regs[rs1_addr]);
    check_word("rs2_rdata", rs2_rdata, m_regs[rs2_addr]);
    check_flag("wb_valid", wb_valid, slot.valid);
    check_trap(trap_redirect_valid, trap_redirect_pc, slot.valid && slot.trap, m_csr[csr_mtvec]);
  endtask

  // Sample mid-cycle, then let the edge advance both DUT and model
  task automatic run_cycle();
    #8;
    check_outputs();
    @(posedge clk_i);
    step_model();
    #2;
  endtask

  initial begin
    int   issued;
    logic take_new;
    void'($urandom(32'h3ad70b78));
    clk_i            = 1'b0;
    reset            = 1'b1;
    mem_wb_stall     = 1'b0;
    ex_mem_stall     = 1'b0;
    mem_wb_flush     = 1'b0;
    mem_q_valid      = 1'b0;
    mem_q_pc         = '0;
    mem_q_mem_op     = mem_none;
    mem_q_alu_result = '0;
    mem_q_store_data = '0;
    mem_q_rd_addr    = '0;
    mem_q_rd_write   = 1'b0;
    mem_q_csr_op     = csr_none;
    mem_q_csr_addr   = '0;
    mem_q_csr_src    = '0;
    rs1_addr         = '0;
    rs2_addr         = '0;
    reset_model();
    repeat (5) begin
      @(posedge clk_i);
      step_model();
    end
    #2;
    reset = 1'b0;
    // Fill the load window so every load sees known data
    for (int w = 0; w < 16; w++) begin
      mem_q_valid      = 1'b1;
      mem_q_mem_op     = mem_sw;
      mem_q_alu_result = 32'(4 * w);
      mem_q_store_data = $urandom;
      drive_read_ports();
      run_cycle();
    end
    issued = 0;
    gen_instruction();
    while (issued < num_insns) begin
      drive_hazards();
      drive_read_ports();
      take_new = mem_wb_flush || (!mem_wb_stall && !ex_mem_stall);
      run_cycle();
      if (take_new) begin
        gen_instruction();
        issued++;
      end
    end
    mem_q_valid  = 1'b0;
    mem_wb_stall = 1'b0;
    ex_mem_stall = 1'b0;
    mem_wb_flush = 1'b0;
    repeat (3) begin
      drive_read_ports();
      run_cycle();
    end
    $display("sim passed");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    abort_run($sformatf("Watchdog expired at %0t before %0d instructions were issued",
                        $time, num_insns));
  end

endmodule

// ==== rtl/back_end_top.sv ====
`timescale 1ns/1ps

module back_end_top #(
  parameter int ram_words = 256
) (
  input  logic                             clk_i,
  input  logic                             reset,
  input  logic                             mem_wb_stall,
  input  logic                             ex_mem_stall,
  input  logic                             mem_wb_flush,
  input  logic                             mem_q_valid,
  input  logic [riscv_pkg::xlen-1:0]       mem_q_pc,
  input  riscv_pkg::mem_op_e               mem_q_mem_op,
  input  logic [riscv_pkg::xlen-1:0]       mem_q_alu_result,
  input  logic [riscv_pkg::xlen-1:0]       mem_q_store_data,
  input  logic [riscv_pkg::reg_addr_w-1:0] mem_q_rd_addr,
  input  logic                             mem_q_rd_write,
  input  riscv_pkg::csr_op_e               mem_q_csr_op,
  input  logic [riscv_pkg::csr_addr_w-1:0] mem_q_csr_addr,
  input  logic [riscv_pkg::xlen-1:0]       mem_q_csr_src,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [riscv_pkg::xlen-1:0]       rs1_rdata,
  output logic [riscv_pkg::xlen-1:0]       rs2_rdata,
  output logic                             wb_valid,
  output logic                             trap_redirect_valid,
  output logic [riscv_pkg::xlen-1:0]       trap_redirect_pc
);
  import riscv_pkg::*;

  logic                  mem_advance;
  logic [csr_addr_w-1:0] csr_raddr;
  logic [xlen-1:0]       csr_rdata;
  logic                  csr_known;

  logic                  mem_d_valid;
  logic [reg_addr_w-1:0] mem_d_rd_addr;
  logic [xlen-1:0]       mem_d_rd_wdata;
  logic                  mem_d_is_rd_write;
  logic [csr_addr_w-1:0] mem_d_csr_addr;
  logic [xlen-1:0]       mem_d_csr_wdata;
  logic                  mem_d_is_csr_write;
  logic                  mem_d_trap_valid;
  logic [xlen-1:0]       mem_d_trap_mcause;
  logic [xlen-1:0]       mem_d_trap_pc;

  logic                  wb_q_valid;
  logic [reg_addr_w-1:0] wb_q_rd_addr;
  logic [xlen-1:0]       wb_q_rd_wdata;
  logic                  wb_q_is_rd_write;
  logic [csr_addr_w-1:0] wb_q_csr_addr;
  logic [xlen-1:0]       wb_q_csr_wdata;
  logic                  wb_q_is_csr_write;
  logic                  wb_q_trap_valid;
  logic [xlen-1:0]       wb_q_trap_mcause;
  logic [xlen-1:0]       wb_q_trap_pc;

  assign wb_valid = wb_q_valid;

  // Net names match the stage ports one to one
  mem_stage #(
    .ram_words(ram_words)
  ) mem_stage_inst (.*);

  mem_wb_pipeline mem_wb_pipeline_inst (.*);

  wb_stage wb_stage_inst (.*);

endmodule

// ==== writeback/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
  input  logic                             clk_i,
  input  logic                             reset,
  input  logic                             wb_q_valid,
  input  logic [riscv_pkg::reg_addr_w-1:0] wb_q_rd_addr,
  input  logic [riscv_pkg::xlen-1:0]       wb_q_rd_wdata,
  input  logic                             wb_q_is_rd_write,
  input  logic [riscv_pkg::csr_addr_w-1:0] wb_q_csr_addr,
  input  logic [riscv_pkg::xlen-1:0]       wb_q_csr_wdata,
  input  logic                             wb_q_is_csr_write,
  input  logic                             wb_q_trap_valid,
  input  logic [riscv_pkg::xlen-1:0]       wb_q_trap_mcause,
  input  logic [riscv_pkg::xlen-1:0]       wb_q_trap_pc,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [riscv_pkg::csr_addr_w-1:0] csr_raddr,
  output logic [riscv_pkg::xlen-1:0]       rs1_rdata,
  output logic [riscv_pkg::xlen-1:0]       rs2_rdata,
  output logic [riscv_pkg::xlen-1:0]       csr_rdata,
  output logic                             csr_known,
  output logic                             trap_redirect_valid,
  output logic [riscv_pkg::xlen-1:0]       trap_redirect_pc
);

  logic rf_we;
  logic csr_we;
  logic trap_en;

  // A trapping instruction only updates mepc and mcause
  assign trap_en = wb_q_valid && wb_q_trap_valid;
  assign rf_we   = wb_q_valid && wb_q_is_rd_write && !wb_q_trap_valid;
  assign csr_we  = wb_q_valid && wb_q_is_csr_write && !wb_q_trap_valid;

  assign trap_redirect_valid = trap_en;

  reg_file reg_file_inst (
    .clk_i     (clk_i),
    .reset     (reset),
    .write_en  (rf_we),
    .write_addr(wb_q_rd_addr),
    .write_data(wb_q_rd_wdata),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_rdata (rs1_rdata),
    .rs2_rdata (rs2_rdata)
  );

  csr_file csr_file_inst (
    .clk_i     (clk_i),
    .reset     (reset),
    .raddr     (csr_raddr),
    .rdata     (csr_rdata),
    .known     (csr_known),
    .write_en  (csr_we),
    .waddr     (wb_q_csr_addr),
    .wdata     (wb_q_csr_wdata),
    .trap_en   (trap_en),
    .trap_pc   (wb_q_trap_pc),
    .trap_cause(wb_q_trap_mcause),
    .mtvec     (trap_redirect_pc)
  );

endmodule

// ==== writeback/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
  input  logic                             clk_i,
  input  logic                             reset,
  input  logic [riscv_pkg::csr_addr_w-1:0] raddr,
  output logic [riscv_pkg::xlen-1:0]       rdata,
  output logic                             known,
  input  logic                             write_en,
  input  logic [riscv_pkg::csr_addr_w-1:0] waddr,
  input  logic [riscv_pkg::xlen-1:0]       wdata,
  input  logic                             trap_en,
  input  logic [riscv_pkg::xlen-1:0]       trap_pc,
  input  logic [riscv_pkg::xlen-1:0]       trap_cause,
  output logic [riscv_pkg::xlen-1:0]       mtvec
);
  import riscv_pkg::*;

  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] stored;

  always_comb begin
    known = 1'b1;
    case (raddr)
      csr_mscratch: stored = mscratch_q;
      csr_mtvec:    stored = mtvec_q;
      csr_mepc:     stored = mepc_q;
      csr_mcause:   stored = mcause_q;
      default: begin
        stored = '0;
        known  = 1'b0;
      end
    endcase
    // Forward whatever WB commits at the coming edge
    rdata = stored;
    if (trap_en && raddr == csr_mepc) begin
      rdata = trap_pc;
    end else if (trap_en && raddr == csr_mcause) begin
      rdata = trap_cause;
    end else if (write_en && waddr == raddr) begin
      rdata = wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (trap_en) begin
      mepc_q   <= trap_pc;
      mcause_q <= trap_cause;
    end else if (write_en) begin
      case (waddr)
        csr_mscratch: mscratch_q <= wdata;
        csr_mtvec:    mtvec_q    <= wdata;
        csr_mepc:     mepc_q     <= wdata;
        csr_mcause:   mcause_q   <= wdata;
        default: ;
      endcase
    end
  end

  assign mtvec = mtvec_q;

endmodule

// ==== writeback/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                             clk_i,
  input  logic                             reset,
  input  logic                             write_en,
  input  logic [riscv_pkg::reg_addr_w-1:0] write_addr,
  input  logic [riscv_pkg::xlen-1:0]       write_data,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [riscv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [riscv_pkg::xlen-1:0]       rs1_rdata,
  output logic [riscv_pkg::xlen-1:0]       rs2_rdata
);
  import riscv_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk_i) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  assign rs1_rdata = regs[rs1_addr];
  assign rs2_rdata = regs[rs2_addr];

  // x0 stays zero even after writes aimed at it
  assert property (@(posedge clk_i) disable iff (reset)
                   (rs1_addr == '0) |-> (rs1_rdata == '0));
  assert property (@(posedge clk_i) disable iff (reset)
                   (rs2_addr == '0) |-> (rs2_rdata == '0));

endmodule

// ==== rtl/mem_wb_pipeline.sv ====
`timescale 1ns/1ps

module mem_wb_pipeline (
  input  logic                             clk_i,
  input  logic                             reset,
  input  logic                             mem_wb_flush,
  input  logic                             mem_wb_stall,
  input  logic                             ex_mem_stall,
  output logic                             mem_advance,
  input  logic                             mem_d_valid,
  input  logic [riscv_pkg::reg_addr_w-1:0] mem_d_rd_addr,
  input  logic [riscv_pkg::xlen-1:0]       mem_d_rd_wdata,
  input  logic                             mem_d_is_rd_write,
  input  logic [riscv_pkg::csr_addr_w-1:0] mem_d_csr_addr,
  input  logic [riscv_pkg::xlen-1:0]       mem_d_csr_wdata,
  input  logic                             mem_d_is_csr_write,
  input  logic                             mem_d_trap_valid,
  input  logic [riscv_pkg::xlen-1:0]       mem_d_trap_mcause,
  input  logic [riscv_pkg::xlen-1:0]       mem_d_trap_pc,
  output logic                             wb_q_valid,
  output logic [riscv_pkg::reg_addr_w-1:0] wb_q_rd_addr,
  output logic [riscv_pkg::xlen-1:0]       wb_q_rd_wdata,
  output logic                             wb_q_is_rd_write,
  output logic [riscv_pkg::csr_addr_w-1:0] wb_q_csr_addr,
  output logic [riscv_pkg::xlen-1:0]       wb_q_csr_wdata,
  output logic                             wb_q_is_csr_write,
  output logic                             wb_q_trap_valid,
  output logic [riscv_pkg::xlen-1:0]       wb_q_trap_mcause,
  output logic [riscv_pkg::xlen-1:0]       wb_q_trap_pc
);

  logic clear;

  // Bubble when EX/MEM holds but WB is free to drain
  assign clear       = reset || mem_wb_flush || (!mem_wb_stall && ex_mem_stall);
  assign mem_advance = !mem_wb_stall && !ex_mem_stall && !mem_wb_flush;

  always_ff @(posedge clk_i) begin
    if (clear) begin
      wb_q_valid        <= 1'b0;
      wb_q_is_rd_write  <= 1'b0;
      wb_q_is_csr_write <= 1'b0;
      wb_q_trap_valid   <= 1'b0;
    end else if (!mem_wb_stall) begin
      wb_q_valid        <= mem_d_valid;
      wb_q_is_rd_write  <= mem_d_is_rd_write;
      wb_q_is_csr_write <= mem_d_is_csr_write;
      wb_q_trap_valid   <= mem_d_trap_valid;
    end
  end

  // Payload only matters while wb_q_valid is set
  always_ff @(posedge clk_i) begin
    if (!mem_wb_stall) begin
      wb_q_rd_addr     <= mem_d_rd_addr;
      wb_q_rd_wdata    <= mem_d_rd_wdata;
      wb_q_csr_addr    <= mem_d_csr_addr;
      wb_q_csr_wdata   <= mem_d_csr_wdata;
      wb_q_trap_mcause <= mem_d_trap_mcause;
      wb_q_trap_pc     <= mem_d_trap_pc;
    end
  end

  // A flushed slot never reaches writeback
  assert property (@(posedge clk_i) mem_wb_flush |=> !wb_q_valid);

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
  parameter int ram_words = 256
) (
  input  logic                                 clk_i,
  input  logic                                 mem_advance,
  input  logic                                 mem_q_valid,
  input  logic [riscv_pkg::xlen-1:0]           mem_q_pc,
  input  riscv_pkg::mem_op_e                   mem_q_mem_op,
  input  logic [riscv_pkg::xlen-1:0]           mem_q_alu_result,
  input  logic [riscv_pkg::xlen-1:0]           mem_q_store_data,
  input  logic [riscv_pkg::reg_addr_w-1:0]     mem_q_rd_addr,
  input  logic                                 mem_q_rd_write,
  input  riscv_pkg::csr_op_e                   mem_q_csr_op,
  input  logic [riscv_pkg::csr_addr_w-1:0]     mem_q_csr_addr,
  input  logic [riscv_pkg::xlen-1:0]           mem_q_csr_src,
  input  logic [riscv_pkg::xlen-1:0]           csr_rdata,
  input  logic                                 csr_known,
  output logic [riscv_pkg::csr_addr_w-1:0]     csr_raddr,
  output logic                                 mem_d_valid,
  output logic [riscv_pkg::reg_addr_w-1:0]     mem_d_rd_addr,
  output logic [riscv_pkg::xlen-1:0]           mem_d_rd_wdata,
  output logic                                 mem_d_is_rd_write,
  output logic [riscv_pkg::csr_addr_w-1:0]     mem_d_csr_addr,
  output logic [riscv_pkg::xlen-1:0]           mem_d_csr_wdata,
  output logic                                 mem_d_is_csr_write,
  output logic                                 mem_d_trap_valid,
  output logic [riscv_pkg::xlen-1:0]           mem_d_trap_mcause,
  output logic [riscv_pkg::xlen-1:0]           mem_d_trap_pc
);
  import riscv_pkg::*;

  localparam int addr_w = $clog2(ram_words);

  logic            is_load;
  logic            is_store;
  logic            misaligned;
  logic            csr_illegal;
  logic            is_csr;
  logic            ram_we;
  logic [3:0]      byte_en;
  logic [xlen-1:0] store_word;
  logic [xlen-1:0] ram_rdata;
  logic [xlen-1:0] load_shifted;
  logic [xlen-1:0] load_data;
  logic [1:0]      offset;

  assign offset = mem_q_alu_result[1:0];

  always_comb begin
    is_load    = 1'b0;
    is_store   = 1'b0;
    misaligned = 1'b0;
    byte_en    = 4'b0000;
    store_word = mem_q_store_data;
    case (mem_q_mem_op)
      mem_lb, mem_lbu: is_load = 1'b1;
      mem_lh, mem_lhu: begin
        is_load    = 1'b1;
        misaligned = offset[0];
      end
      mem_lw: begin
        is_load    = 1'b1;
        misaligned = |offset;
      end
      mem_sb: begin
        is_store   = 1'b1;
        byte_en    = 4'b0001 << offset;
        store_word = {4{mem_q_store_data[7:0]}};
      end
      mem_sh: begin
        is_store   = 1'b1;
        misaligned = offset[0];
        byte_en    = 4'b0011 << offset;
        store_word = {2{mem_q_store_data[15:0]}};
      end
      mem_sw: begin
        is_store   = 1'b1;
        misaligned = |offset;
        byte_en    = 4'b1111;
      end
      default: ;
    endcase
  end

  // Load lane select and extension
  always_comb begin
    load_shifted = ram_rdata >> {offset, 3'b000};
    case (mem_q_mem_op)
      mem_lb:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
      mem_lbu: load_data = {24'b0, load_shifted[7:0]};
      mem_lh:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
      mem_lhu: load_data = {16'b0, load_shifted[15:0]};
      default: load_data = load_shifted;
    endcase
  end

  // Read-modify-write of the old CSR value
  always_comb begin
    case (mem_q_csr_op)
      csr_rw:  mem_d_csr_wdata = mem_q_csr_src;
      csr_rs:  mem_d_csr_wdata = csr_rdata | mem_q_csr_src;
      csr_rc:  mem_d_csr_wdata = csr_rdata & ~mem_q_csr_src;
      default: mem_d_csr_wdata = csr_rdata;
    endcase
  end

  assign is_csr      = mem_q_csr_op != csr_none;
  assign csr_illegal = is_csr && !csr_known;
  assign csr_raddr   = mem_q_csr_addr;

  assign mem_d_trap_valid  = mem_q_valid && (misaligned || csr_illegal);
  assign mem_d_trap_mcause = csr_illegal ? cause_illegal_insn :
                             is_store    ? cause_store_misaligned : cause_load_misaligned;
  assign mem_d_trap_pc     = mem_q_pc;

  // Memory is only touched by the instruction leaving MEM this cycle
  assign ram_we = mem_advance && mem_q_valid && is_store && !mem_d_trap_valid;

  assign mem_d_valid        = mem_q_valid;
  assign mem_d_rd_addr      = mem_q_rd_addr;
  assign mem_d_is_rd_write  = mem_q_rd_write;
  assign mem_d_csr_addr     = mem_q_csr_addr;
  assign mem_d_is_csr_write = is_csr;
  assign mem_d_rd_wdata     = is_load ? load_data :
                              is_csr  ? csr_rdata : mem_q_alu_result;

  data_ram #(
    .ram_words(ram_words)
  ) data_ram_inst (
    .clk_i     (clk_i),
    .write_en  (ram_we),
    .byte_en   (byte_en),
    .word_addr (mem_q_alu_result[addr_w+1:2]),
    .write_data(store_word),
    .read_data (ram_rdata)
  );

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
  parameter int ram_words = 256
) (
  input  logic                         clk_i,
  input  logic                         write_en,
  input  logic [3:0]                   byte_en,
  input  logic [$clog2(ram_words)-1:0] word_addr,
  input  logic [31:0]                  write_data,
  output logic [31:0]                  read_data
);

  logic [31:0] mem [ram_words];

  assign read_data = mem[word_addr];

  always_ff @(posedge clk_i) begin
    if (write_en) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          mem[word_addr][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
  end

  // A store always touches at least one byte lane
  assert property (@(posedge clk_i) write_en |-> byte_en != 4'b0000);

endmodule

// ==== common/riscv_pkg.sv ====
package riscv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb,
    mem_lh,
    mem_lw,
    mem_lbu,
    mem_lhu,
    mem_sb,
    mem_sh,
    mem_sw
  } mem_op_e;

  typedef enum logic [1:0] {
    csr_none,
    csr_rw,
    csr_rs,
    csr_rc
  } csr_op_e;

  // Machine-mode CSRs implemented in writeback
  localparam logic [csr_addr_w-1:0] csr_mtvec    = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;

  localparam logic [xlen-1:0] cause_illegal_insn     = 32'd2;
  localparam logic [xlen-1:0] cause_load_misaligned  = 32'd4;
  localparam logic [xlen-1:0] cause_store_misaligned = 32'd6;

endpackage
